// File: hw/fft_defines.svh
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// --------------------
// datapath widths
// --------------------

// width of one real or imaginary part
`define FFT_SAMPLE_W 17

// twiddles are Q13, 8192 is 1.0
`define FFT_TWIDDLE_FRAC 13

// --------------------
// frame shape
// --------------------

`define FFT_POINTS 8

// cycles from valid_i to valid_o
`define FFT_LATENCY 2

`endif

// File: hw/fft_pkg.sv
`default_nettype none

`include "fft_defines.svh"

package fft_pkg;

    // --------------------
    // datapath types
    // --------------------

    // real or imaginary part of a sample or a bin
    // all adds wrap modulo 2**17
    typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

    // real or imaginary part of a twiddle factor, Q13
    typedef logic signed [`FFT_SAMPLE_W-1:0] twiddle_t;

    // full precision product of a sample and a twiddle
    typedef logic signed [2*`FFT_SAMPLE_W-1:0] product_t;

endpackage

`default_nettype wire

// File: hw/twiddle_mult.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module twiddle_mult (
    input  wire fft_pkg::sample_t  a_re_i,
    input  wire fft_pkg::sample_t  a_im_i,
    input  wire fft_pkg::twiddle_t w_re_i,
    input  wire fft_pkg::twiddle_t w_im_i,
    output fft_pkg::sample_t       p_re_o,
    output fft_pkg::sample_t       p_im_o
);

    // partial products, a+jb times c+jd
    fft_pkg::product_t ac;
    fft_pkg::product_t bd;
    fft_pkg::product_t ad;
    fft_pkg::product_t bc;

    // combined parts before scaling
    fft_pkg::product_t sum_re;
    fft_pkg::product_t sum_im;

    assign ac = a_re_i * w_re_i;
    assign bd = a_im_i * w_im_i;
    assign ad = a_re_i * w_im_i;
    assign bc = a_im_i * w_re_i;

    assign sum_re = ac - bd;
    assign sum_im = ad + bc;

    // drop the 13 fraction bits, keep 17 bits above them
    // this floors toward minus infinity and wraps on overflow
    assign p_re_o = sum_re[`FFT_TWIDDLE_FRAC+`FFT_SAMPLE_W-1:`FFT_TWIDDLE_FRAC];
    assign p_im_o = sum_im[`FFT_TWIDDLE_FRAC+`FFT_SAMPLE_W-1:`FFT_TWIDDLE_FRAC];

endmodule

`default_nettype wire

// File: hw/fft_stage1.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module fft_stage1 (
    // input frame, natural order
    input  wire fft_pkg::sample_t  x_re_i [0:`FFT_POINTS-1],
    input  wire fft_pkg::sample_t  x_im_i [0:`FFT_POINTS-1],

    // W8^0 .. W8^3 in Q13
    input  wire fft_pkg::twiddle_t w_re_i [0:`FFT_POINTS/2-1],
    input  wire fft_pkg::twiddle_t w_im_i [0:`FFT_POINTS/2-1],

    // 0..3 carry the sums, 4..7 the rotated differences
    output fft_pkg::sample_t       s_re_o [0:`FFT_POINTS-1],
    output fft_pkg::sample_t       s_im_o [0:`FFT_POINTS-1]
);

    localparam int HALF = `FFT_POINTS / 2;

    // differences before rotation
    fft_pkg::sample_t d_re [0:HALF-1];
    fft_pkg::sample_t d_im [0:HALF-1];

    // --------------------
    // first DIF column
    // --------------------

    genvar k;
    generate
        for (k = 0; k < HALF; k++) begin : g_bfly
            // upper leg passes on unrotated
            assign s_re_o[k] = x_re_i[k] + x_re_i[k+HALF];
            assign s_im_o[k] = x_im_i[k] + x_im_i[k+HALF];

            assign d_re[k] = x_re_i[k] - x_re_i[k+HALF];
            assign d_im[k] = x_im_i[k] - x_im_i[k+HALF];

            // lower leg is rotated by W8^k
            twiddle_mult u_twiddle_mult (
                .a_re_i (d_re[k]),
                .a_im_i (d_im[k]),
                .w_re_i (w_re_i[k]),
                .w_im_i (w_im_i[k]),
                .p_re_o (s_re_o[k+HALF]),
                .p_im_o (s_im_o[k+HALF])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/fft_stage2.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module fft_stage2 (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             valid_i,

    // stage 1 results, combinational
    input  wire fft_pkg::sample_t s_re_i [0:`FFT_POINTS-1],
    input  wire fft_pkg::sample_t s_im_i [0:`FFT_POINTS-1],

    // registered second column
    output fft_pkg::sample_t      r_re_o [0:`FFT_POINTS-1],
    output fft_pkg::sample_t      r_im_o [0:`FFT_POINTS-1],
    output logic                  valid_o
);

    localparam int QUARTER = `FFT_POINTS / 4;

    // butterfly outputs ahead of the register bank
    fft_pkg::sample_t b_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t b_im [0:`FFT_POINTS-1];

    // --------------------
    // second DIF column
    // --------------------

    // each half of the frame is a 4-point group with stride 2
    genvar h;
    genvar j;
    generate
        for (h = 0; h < 2; h++) begin : g_half
            for (j = 0; j < QUARTER; j++) begin : g_pair
                localparam int BASE = h * 2 * QUARTER;

                assign b_re[BASE+j] = s_re_i[BASE+j] + s_re_i[BASE+j+QUARTER];
                assign b_im[BASE+j] = s_im_i[BASE+j] + s_im_i[BASE+j+QUARTER];

                assign b_re[BASE+j+QUARTER] = s_re_i[BASE+j] - s_re_i[BASE+j+QUARTER];
                assign b_im[BASE+j+QUARTER] = s_im_i[BASE+j] - s_im_i[BASE+j+QUARTER];
            end
        end
    endgenerate

    // --------------------
    // first pipeline bank
    // --------------------

    // data loads every cycle, valid just travels alongside
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `FFT_POINTS; i++) begin
                r_re_o[i] <= '0;
                r_im_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            for (int i = 0; i < `FFT_POINTS; i++) begin
                r_re_o[i] <= b_re[i];
                r_im_o[i] <= b_im[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/fft_stage3.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module fft_stage3 (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             valid_i,

    // first pipeline bank
    input  wire fft_pkg::sample_t r_re_i [0:`FFT_POINTS-1],
    input  wire fft_pkg::sample_t r_im_i [0:`FFT_POINTS-1],

    // final bins, bit-reversed order
    output fft_pkg::sample_t      y_re_o [0:`FFT_POINTS-1],
    output fft_pkg::sample_t      y_im_o [0:`FFT_POINTS-1],
    output logic                  valid_o
);

    // inputs after the -j rotation
    fft_pkg::sample_t t_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t t_im [0:`FFT_POINTS-1];

    // butterfly outputs ahead of the register bank
    fft_pkg::sample_t b_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t b_im [0:`FFT_POINTS-1];

    // --------------------
    // -j rotation
    // --------------------

    // W8^2 = -j on the odd element of each lower pair,
    // (re + j*im) * -j = im - j*re, no multiplier needed
    always_comb begin
        for (int i = 0; i < `FFT_POINTS; i++) begin
            if (i % 4 == 3) begin
                t_re[i] = r_im_i[i];
                t_im[i] = -r_re_i[i];
            end else begin
                t_re[i] = r_re_i[i];
                t_im[i] = r_im_i[i];
            end
        end
    end

    // --------------------
    // third DIF column
    // --------------------

    // sum goes to the even slot, difference to the odd slot
    genvar p;
    generate
        for (p = 0; p < `FFT_POINTS / 2; p++) begin : g_pair
            assign b_re[2*p]   = t_re[2*p] + t_re[2*p+1];
            assign b_im[2*p]   = t_im[2*p] + t_im[2*p+1];
            assign b_re[2*p+1] = t_re[2*p] - t_re[2*p+1];
            assign b_im[2*p+1] = t_im[2*p] - t_im[2*p+1];
        end
    endgenerate

    // --------------------
    // output bank
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `FFT_POINTS; i++) begin
                y_re_o[i] <= '0;
                y_im_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            for (int i = 0; i < `FFT_POINTS; i++) begin
                y_re_o[i] <= b_re[i];
                y_im_o[i] <= b_im[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/fft_8pt.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

// 8-point radix-2 DIF FFT, one frame per clock
// bins come out bit-reversed, index m holds bin bitrev3(m)
module fft_8pt (
    input  wire logic              clk,
    input  wire logic              reset_n,

    // frame strobe, no back-pressure
    input  wire logic              valid_i,

    // input samples, natural order
    input  wire fft_pkg::sample_t  xi_re_i [0:`FFT_POINTS-1],
    input  wire fft_pkg::sample_t  xi_im_i [0:`FFT_POINTS-1],

    // W8^0 .. W8^3, Q13
    input  wire fft_pkg::twiddle_t w_re_i  [0:`FFT_POINTS/2-1],
    input  wire fft_pkg::twiddle_t w_im_i  [0:`FFT_POINTS/2-1],

    // result bins, two cycles after the frame
    output fft_pkg::sample_t       xo_re_o [0:`FFT_POINTS-1],
    output fft_pkg::sample_t       xo_im_o [0:`FFT_POINTS-1],
    output logic                   valid_o
);

    // --------------------
    // inter-stage signals
    // --------------------

    // stage 1 out, combinational
    fft_pkg::sample_t s1_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t s1_im [0:`FFT_POINTS-1];

    // stage 2 out, first register bank
    fft_pkg::sample_t s2_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t s2_im [0:`FFT_POINTS-1];
    logic             s2_valid;

    // --------------------
    // stages
    // --------------------

    // sums and twiddled differences
    fft_stage1 u_stage1 (
        .x_re_i (xi_re_i),
        .x_im_i (xi_im_i),
        .w_re_i (w_re_i),
        .w_im_i (w_im_i),
        .s_re_o (s1_re),
        .s_im_o (s1_im)
    );

    // second column, registered
    fft_stage2 u_stage2 (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (valid_i),
        .s_re_i  (s1_re),
        .s_im_i  (s1_im),
        .r_re_o  (s2_re),
        .r_im_o  (s2_im),
        .valid_o (s2_valid)
    );

    // -j rotation and last column, registered
    fft_stage3 u_stage3 (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (s2_valid),
        .r_re_i  (s2_re),
        .r_im_i  (s2_im),
        .y_re_o  (xo_re_o),
        .y_im_o  (xo_im_o),
        .valid_o (valid_o)
    );

endmodule

`default_nettype wire

// File: bench/fft_8pt_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module fft_8pt_assertions (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             valid_i,
    input  wire logic             valid_o,
    input  wire fft_pkg::sample_t xo_re_o [0:`FFT_POINTS-1],
    input  wire fft_pkg::sample_t xo_im_o [0:`FFT_POINTS-1]
);

    // number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // --------------------
    // valid timing
    // --------------------

    // valid_o repeats valid_i once both register banks are out of reset
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        ($past(reset_n, 1) && $past(reset_n, `FFT_LATENCY)) |->
            (valid_o == $past(valid_i, `FFT_LATENCY))
    ) else begin
        $error("valid_o does not follow valid_i by the pipeline latency");
        fail_count++;
    end

    // output valid flop clears on the first low reset edge
    a_reset_clears_valid: assert property (
        @(posedge clk) !reset_n |=> !valid_o
    ) else begin
        $error("valid_o still high one cycle after reset");
        fail_count++;
    end

    // --------------------
    // output data
    // --------------------

    genvar g;
    generate
        for (g = 0; g < `FFT_POINTS; g++) begin : g_known
            a_no_x: assert property (
                @(posedge clk) valid_o |-> !$isunknown({xo_re_o[g], xo_im_o[g]})
            ) else begin
                $error("unknown bits on output bin slot while valid_o is high");
                fail_count++;
            end
        end
    endgenerate

endmodule

bind fft_8pt fft_8pt_assertions u_assertions (
    .clk     (clk),
    .reset_n (reset_n),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .xo_re_o (xo_re_o),
    .xo_im_o (xo_im_o)
);

`default_nettype wire

// File: bench/fft_8pt_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fft_defines.svh"

module fft_8pt_tb;

    localparam int RESET_CYCLES = 5;
    localparam int N_B2B = 40;
    localparam int N_GAP = 60;
    localparam int N_FULL = 40;
    // each frame test ends with an idle frame and the pipeline drain
    localparam int DRAIN = `FFT_LATENCY + 4;
    localparam int MAX_CYCLES = RESET_CYCLES + 2 + N_B2B + N_GAP + N_FULL + 4 * DRAIN + 50;

    typedef logic [`FFT_POINTS-1:0][`FFT_SAMPLE_W-1:0] vec_t;
    typedef logic [`FFT_POINTS/2-1:0][`FFT_SAMPLE_W-1:0] tvec_t;
    typedef struct packed {
        vec_t re;
        vec_t im;
    } cframe_t;

    logic              clk;
    logic              reset_n;
    logic              valid_i;
    fft_pkg::sample_t  xi_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t  xi_im [0:`FFT_POINTS-1];
    fft_pkg::twiddle_t w_re  [0:`FFT_POINTS/2-1];
    fft_pkg::twiddle_t w_im  [0:`FFT_POINTS/2-1];
    fft_pkg::sample_t  xo_re [0:`FFT_POINTS-1];
    fft_pkg::sample_t  xo_im [0:`FFT_POINTS-1];
    logic              valid_o;

    integer  seed = 70;
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    logic    checking = 1'b0;
    logic [`FFT_LATENCY-1:0] vpipe;
    cframe_t exp_q [$];
    tvec_t   std_wr;
    tvec_t   std_wi;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    fft_8pt dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (valid_i),
        .xi_re_i (xi_re),
        .xi_im_i (xi_im),
        .w_re_i  (w_re),
        .w_im_i  (w_im),
        .xo_re_o (xo_re),
        .xo_im_o (xo_im),
        .valid_o (valid_o)
    );

    // --------------------
    // reference model
    // --------------------

    // three DIF columns on wrapped 17-bit values
    function automatic cframe_t fft_ref(input cframe_t x, input tvec_t wr, input tvec_t wi);
        fft_pkg::sample_t  a_re [0:7];
        fft_pkg::sample_t  a_im [0:7];
        fft_pkg::sample_t  b_re [0:7];
        fft_pkg::sample_t  b_im [0:7];
        fft_pkg::sample_t  dr;
        fft_pkg::sample_t  di;
        fft_pkg::sample_t  t;
        fft_pkg::twiddle_t c;
        fft_pkg::twiddle_t d;
        longint            pr;
        longint            pi;
        cframe_t           y;
        int                k;
        int                h;
        for (k = 0; k < 4; k++) begin
            a_re[k] = x.re[k] + x.re[k+4];
            a_im[k] = x.im[k] + x.im[k+4];
            dr = x.re[k] - x.re[k+4];
            di = x.im[k] - x.im[k+4];
            c = wr[k];
            d = wi[k];
            // Q13 product floored by the arithmetic shift
            pr = (longint'(dr) * longint'(c) - longint'(di) * longint'(d)) >>> `FFT_TWIDDLE_FRAC;
            pi = (longint'(dr) * longint'(d) + longint'(di) * longint'(c)) >>> `FFT_TWIDDLE_FRAC;
            a_re[k+4] = pr[`FFT_SAMPLE_W-1:0];
            a_im[k+4] = pi[`FFT_SAMPLE_W-1:0];
        end
        for (h = 0; h < 8; h += 4) begin
            for (k = 0; k < 2; k++) begin
                b_re[h+k] = a_re[h+k] + a_re[h+k+2];
                b_im[h+k] = a_im[h+k] + a_im[h+k+2];
                b_re[h+k+2] = a_re[h+k] - a_re[h+k+2];
                b_im[h+k+2] = a_im[h+k] - a_im[h+k+2];
            end
        end
        // times -j on slots 3 and 7
        for (h = 3; h < 8; h += 4) begin
            t = b_re[h];
            b_re[h] = b_im[h];
            b_im[h] = -t;
        end
        // in-place DIF leaves bin bitrev3(m) in slot m
        for (k = 0; k < 8; k += 2) begin
            y.re[k] = b_re[k] + b_re[k+1];
            y.im[k] = b_im[k] + b_im[k+1];
            y.re[k+1] = b_re[k] - b_re[k+1];
            y.im[k+1] = b_im[k] - b_im[k+1];
        end
        return y;
    endfunction

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_sample(input string name, input int idx,
                                input fft_pkg::sample_t exp_v, input fft_pkg::sample_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("FAILED at %0d ns: %s[%0d] expected %0d, got %0d",
                     $time, name, idx, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_valid(input logic exp_v, input logic act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("FAILED at %0d ns: valid_o expected %b, got %b", $time, exp_v, act_v);
            errors++;
        end
    endtask

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic fft_pkg::sample_t small_sample();
        return fft_pkg::sample_t'($random(seed) % 1024);
    endfunction

    // mostly values hugging either end of the 17-bit range
    function automatic fft_pkg::sample_t full_sample();
        integer           r;
        fft_pkg::sample_t s;
        r = $random(seed);
        case (r[1:0])
            2'd0:    s = 65535 - r[6:2];
            2'd1:    s = -65536 + r[6:2];
            default: s = r[18:2];
        endcase
        return s;
    endfunction

    function automatic cframe_t random_frame(input logic full);
        cframe_t x;
        int      k;
        for (k = 0; k < `FFT_POINTS; k++) begin
            x.re[k] = full ? full_sample() : small_sample();
            x.im[k] = full ? full_sample() : small_sample();
        end
        return x;
    endfunction

    task automatic random_twiddle(output tvec_t wr, output tvec_t wi);
        int k;
        for (k = 0; k < `FFT_POINTS / 2; k++) begin
            wr[k] = fft_pkg::twiddle_t'($random(seed));
            wi[k] = fft_pkg::twiddle_t'($random(seed));
        end
    endtask

    // one frame per call with e as its expected result
    task automatic drive_frame(input cframe_t x, input tvec_t wr, input tvec_t wi,
                               input logic v, input cframe_t e);
        int k;
        @(posedge clk);
        #2;
        valid_i = v;
        for (k = 0; k < `FFT_POINTS; k++) begin
            xi_re[k] = x.re[k];
            xi_im[k] = x.im[k];
        end
        for (k = 0; k < `FFT_POINTS / 2; k++) begin
            w_re[k] = wr[k];
            w_im[k] = wi[k];
        end
        if (v)
            exp_q.push_back(e);
    endtask

    task automatic drain();
        cframe_t zero;
        zero = '0;
        drive_frame(zero, std_wr, std_wi, 1'b0, zero);
        while (exp_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int start_errors);
        $display("test %0d %s: %0d errors", num, name, errors - start_errors);
    endtask

    // --------------------
    // output checking
    // --------------------

    // expected valid delayed like the two register banks
    always @(posedge clk) begin
        if (!reset_n)
            vpipe <= '0;
        else
            vpipe <= {vpipe[`FFT_LATENCY-2:0], valid_i};
    end

    always @(negedge clk) begin : compare
        cframe_t e;
        int      k;
        if (checking) begin
            check_valid(vpipe[`FFT_LATENCY-1], valid_o);
            if (valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("valid_o went high at %0d ns with no frame waiting", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    for (k = 0; k < `FFT_POINTS; k++) begin
                        check_sample("xo_re_o", k, e.re[k], xo_re[k]);
                        check_sample("xo_im_o", k, e.im[k], xo_im[k]);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles before the tests finished", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------
    // test sequence
    // --------------------

    initial begin : main
        cframe_t x;
        cframe_t e;
        tvec_t   wr;
        tvec_t   wi;
        logic    v;
        int      n;
        int      k;
        int      start_errors;
        int      asrt;

        reset_n = 1'b0;
        valid_i = 1'b0;
        for (k = 0; k < `FFT_POINTS; k++) begin
            xi_re[k] = '0;
            xi_im[k] = '0;
        end
        for (k = 0; k < `FFT_POINTS / 2; k++) begin
            w_re[k] = '0;
            w_im[k] = '0;
        end
        // W8^0 .. W8^3 in Q13
        std_wr[0] = 8192;
        std_wi[0] = 0;
        std_wr[1] = 5793;
        std_wi[1] = -5793;
        std_wr[2] = 0;
        std_wi[2] = -8192;
        std_wr[3] = -5793;
        std_wi[3] = -5793;

        // test 1 checks that everything is cleared while reset is held
        start_errors = errors;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_valid(1'b0, valid_o);
        for (k = 0; k < `FFT_POINTS; k++) begin
            check_sample("xo_re_o", k, '0, xo_re[k]);
            check_sample("xo_im_o", k, '0, xo_im[k]);
        end
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        checking = 1'b1;
        report_test(1, "reset", start_errors);

        // test 2 spreads an impulse to every bin and puts DC in bin 0
        start_errors = errors;
        x = '0;
        x.re[0] = 1234;
        x.im[0] = -567;
        for (k = 0; k < `FFT_POINTS; k++) begin
            e.re[k] = 1234;
            e.im[k] = -567;
        end
        drive_frame(x, std_wr, std_wi, 1'b1, e);
        for (k = 0; k < `FFT_POINTS; k++) begin
            x.re[k] = 1000;
            x.im[k] = -300;
        end
        e = '0;
        e.re[0] = 8000;
        e.im[0] = -2400;
        drive_frame(x, std_wr, std_wi, 1'b1, e);
        drain();
        report_test(2, "impulse and DC", start_errors);

        // test 3
        start_errors = errors;
        for (n = 0; n < N_B2B; n++) begin
            x = random_frame(1'b0);
            drive_frame(x, std_wr, std_wi, 1'b1, fft_ref(x, std_wr, std_wi));
        end
        drain();
        report_test(3, "back-to-back frames", start_errors);

        // test 4 keeps random data on invalid frames
        start_errors = errors;
        for (n = 0; n < N_GAP; n++) begin
            x = random_frame(1'b0);
            v = ($random(seed) & 3) != 0;
            drive_frame(x, std_wr, std_wi, v, fft_ref(x, std_wr, std_wi));
        end
        drain();
        report_test(4, "gapped valid", start_errors);

        // test 5
        start_errors = errors;
        for (n = 0; n < N_FULL; n++) begin
            random_twiddle(wr, wi);
            x = random_frame(1'b1);
            drive_frame(x, wr, wi, 1'b1, fft_ref(x, wr, wi));
        end
        drain();
        report_test(5, "random twiddles, full range", start_errors);

        asrt = dut_i.u_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fft_8pt.f
+incdir+hw
hw/fft_pkg.sv
hw/twiddle_mult.sv
hw/fft_stage1.sv
hw/fft_stage2.sv
hw/fft_stage3.sv
hw/fft_8pt.sv
bench/fft_8pt_assertions.sv
bench/fft_8pt_tb.sv
